// ==== g15_code_pkg.sv ====
// G-15 side codes as presented on the output levels; LEV1 is the lsb and LEV4 is ignored for numeric controls
package g15_code_pkg;

    // ------------------------------
    // level word
    // ------------------------------
    localparam int lev_w = 5;               // LEV1..LEV5

    typedef logic [lev_w:1] lev_t;          // bit 1 is LEV1
    typedef logic [5:0]     an_code_t;      // {alpha6, alpha5, LEV4..LEV1}

    // ------------------------------
    // numeric controls, LEV5 clear
    // ------------------------------
    localparam lev_t code_num_space  = 5'b00000;
    localparam lev_t code_num_minus  = 5'b00001;
    localparam lev_t code_num_cr     = 5'b00010;
    localparam lev_t code_num_tab    = 5'b00011;
    localparam lev_t code_num_period = 5'b00110;

    // ------------------------------
    // alphanumeric controls
    // ------------------------------
    localparam an_code_t code_an_cr    = 6'b101010;
    localparam an_code_t code_an_tab   = 6'b101101;
    localparam an_code_t code_an_space = 6'b111101;

endpackage

// ==== typewriter_pkg.sv ====
// IBM I/O Writer magnet numbers and relay timing; all times are ms ticks and must fit 5 bits
package typewriter_pkg;

    // ------------------------------
    // typebar magnets
    // ------------------------------
    localparam int mag_count = 44;

    typedef logic [mag_count-1:0] mag_t;    // index = IBM magnet number

    // shifted specials
    localparam logic [5:0] mag_slash  = 6'd40;  // /
    localparam logic [5:0] mag_star   = 6'd43;  // * and unshifted -
    localparam logic [5:0] mag_rparen = 6'd35;  // )
    localparam logic [5:0] mag_lparen = 6'd31;  // (
    localparam logic [5:0] mag_equal  = 6'd15;  // =
    localparam logic [5:0] mag_dollar = 6'd11;  // $
    localparam logic [5:0] mag_plus   = 6'd3;   // +

    // digits
    localparam logic [5:0] mag_0 = 6'd35;
    localparam logic [5:0] mag_1 = 6'd39;
    localparam logic [5:0] mag_2 = 6'd3;
    localparam logic [5:0] mag_3 = 6'd7;
    localparam logic [5:0] mag_4 = 6'd11;
    localparam logic [5:0] mag_5 = 6'd15;
    localparam logic [5:0] mag_6 = 6'd19;
    localparam logic [5:0] mag_7 = 6'd23;
    localparam logic [5:0] mag_8 = 6'd27;
    localparam logic [5:0] mag_9 = 6'd31;

    // ------------------------------
    // relay timing
    // ------------------------------
    typedef logic [4:0] tick_cnt_t;

    localparam tick_cnt_t ticks_pick      = 5'd10;
    localparam tick_cnt_t ticks_drop      = 5'd10;
    localparam tick_cnt_t ticks_drop_slow = 5'd20;  // diode bypassed coil
    localparam tick_cnt_t ticks_pick_int  = 5'd15;  // RY11B interlock

endpackage

// ==== relay_if.sv ====
// buffered relay contacts; all members are levels that follow relay timing, never pulses
interface relay_if;

    g15_code_pkg::lev_t lev;    // RY5..RY1
    logic               alpha5; // RY6, first frame LEV1
    logic               alpha6; // RY7, first frame LEV2
    logic               an;     // RY8
    logic               exc;    // RY9, type pulse
    logic               type_on;// RY10

    modport capture (
        output lev, alpha5, alpha6, an, exc, type_on
    );

    modport decode (
        input lev, alpha5, alpha6, an, exc, type_on
    );

    modport shift (
        input lev, an, type_on
    );

endinterface

// ==== relay.sv ====
// pick/drop relay; tick is a one-clock pulse and a drop is taken when the coil input is all zero
module relay #(
    parameter type payload_t = logic,
    parameter typewriter_pkg::tick_cnt_t t_pick     = typewriter_pkg::ticks_pick,
    parameter typewriter_pkg::tick_cnt_t t_drop     = typewriter_pkg::ticks_drop,
    parameter typewriter_pkg::tick_cnt_t t_drop_alt = typewriter_pkg::ticks_drop
) (
    input  logic     CLOCK,
    input  logic     reset,
    input  logic     tick,      // 1 ms strobe
    input  payload_t e,         // coil energize
    input  logic     ar,        // alternate release path
    output payload_t c          // contacts
);

    payload_t                  e_q;     // coil seen last clock
    typewriter_pkg::tick_cnt_t cnt;     // ticks since coil settled
    typewriter_pkg::tick_cnt_t limit;   // ticks needed for this move

    always_comb begin
        if (e != '0) limit = t_pick;
        else if (ar) limit = t_drop_alt;
        else         limit = t_drop;
    end

    always_ff @(posedge CLOCK) begin
        if (reset) begin
            c   <= '0;                      // all contacts released
            e_q <= '0;
            cnt <= '0;
        end else begin
            e_q <= e;
            if (e == c || e != e_q) begin
                cnt <= '0;                  // idle, or coil still moving
            end else if (tick) begin
                if (cnt >= limit - 1'b1) begin
                    c   <= e;               // armature settles
                    cnt <= '0;
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

    // contacts move only on a ms strobe
    a_tick_only: assert property (@(posedge CLOCK) disable iff (reset)
        c != $past(c) |-> $past(tick));

endmodule

// ==== relay_capture.sv ====
// input relay bank RY1-RY10; levels and exc pass only after TYPE has picked RY10
module relay_capture (
    input  logic               CLOCK,
    input  logic               reset,
    input  logic               tick_ms,
    input  logic               an_in,     // AS
    input  logic               type_in,   // TYPE
    input  logic               exc_in,    // type pulse
    input  g15_code_pkg::lev_t lev_in,
    relay_if.capture           bus
);

    logic [4:1] ry_lev_e;       // RY1..RY4 coils
    logic [4:1] ry_lev;
    logic       ry5_e;
    logic       ry5;            // LEV5
    logic [1:0] ry_alpha_e;     // {RY7, RY6}
    logic [1:0] ry_alpha;
    logic       ry9_e;

    // ------------------------------
    // level buffer
    // ------------------------------
    assign ry_lev_e = {4{bus.type_on}} & lev_in[4:1];
    assign ry5_e    = bus.type_on & lev_in[5];
    assign ry9_e    = bus.type_on & exc_in;

    relay #(.payload_t(logic [4:1]), .t_drop(typewriter_pkg::ticks_drop_slow)) ry1_4 (
        .CLOCK, .reset, .tick(tick_ms), .e(ry_lev_e), .ar(1'b0), .c(ry_lev));

    // fast release in AN so the alpha frame clears quickly
    relay #(.t_drop(typewriter_pkg::ticks_drop_slow)) ry5_lev5 (
        .CLOCK, .reset, .tick(tick_ms), .e(ry5_e), .ar(bus.an), .c(ry5));

    assign bus.lev = {ry5, ry_lev};

    // ------------------------------
    // alpha buffer RY6/RY7
    // ------------------------------
    assign ry_alpha_e = ({2{bus.an & ry5}} & ry_lev[2:1])        // first frame picks
                      | ({2{bus.type_on & ~ry5}} & ry_alpha);    // hold for second frame

    relay #(.payload_t(logic [1:0])) ry6_7 (
        .CLOCK, .reset, .tick(tick_ms), .e(ry_alpha_e), .ar(1'b0), .c(ry_alpha));

    assign bus.alpha6 = ry_alpha[1];
    assign bus.alpha5 = ry_alpha[0];

    // ------------------------------
    // mode and strobe
    // ------------------------------
    relay ry8_an (
        .CLOCK, .reset, .tick(tick_ms), .e(an_in), .ar(1'b0), .c(bus.an));

    relay ry9_exc (
        .CLOCK, .reset, .tick(tick_ms), .e(ry9_e), .ar(1'b0), .c(bus.exc));

    relay ry10_type (
        .CLOCK, .reset, .tick(tick_ms), .e(type_in), .ar(1'b0), .c(bus.type_on));

endmodule

// ==== char_decoder.sv ====
// character to magnet decode, pure combinational; shifted specials leave magnet drive to shift control
module char_decoder (
    relay_if.decode              bus,
    output typewriter_pkg::mag_t mag_base,
    output logic                 mag_cr,
    output logic                 mag_tab,
    output logic                 mag_space,
    output logic                 special,       // shifted symbol pending
    output logic [5:0]           special_mag
);

    localparam logic [5:0] none = 6'h3f;        // no magnet selected

    localparam logic [5:0] digit_mag [10] = '{
        typewriter_pkg::mag_0, typewriter_pkg::mag_1, typewriter_pkg::mag_2,
        typewriter_pkg::mag_3, typewriter_pkg::mag_4, typewriter_pkg::mag_5,
        typewriter_pkg::mag_6, typewriter_pkg::mag_7, typewriter_pkg::mag_8,
        typewriter_pkg::mag_9
    };

    g15_code_pkg::lev_t     num_code;   // LEV4 masked for controls
    g15_code_pkg::an_code_t an_code;
    logic [5:0]             hit;        // typebar magnet
    logic [5:0]             spec;       // shifted magnet

    always_comb begin
        mag_base  = '0;
        mag_cr    = 1'b0;
        mag_tab   = 1'b0;
        mag_space = 1'b0;
        hit       = none;
        spec      = none;
        num_code  = bus.lev;
        if (!bus.lev[5]) num_code[4] = 1'b0;
        an_code   = {bus.alpha6, bus.alpha5, bus.lev[4:1]};

        // ------------------------------
        // numeric (hex) mode
        // ------------------------------
        if (bus.exc && !bus.an) begin
            if (num_code[5] && num_code[4:1] <= 4'd9) begin
                hit = digit_mag[num_code[4:1]];
            end else begin
                unique0 case (num_code)
                    g15_code_pkg::code_num_space:  mag_space = 1'b1;
                    g15_code_pkg::code_num_minus:  hit = typewriter_pkg::mag_star;
                    g15_code_pkg::code_num_cr:     mag_cr = 1'b1;
                    g15_code_pkg::code_num_tab:    mag_tab = 1'b1;
                    g15_code_pkg::code_num_period: hit = 6'd36;
                    5'b11010: hit = 6'd25;  // u
                    5'b11011: hit = 6'd16;  // v
                    5'b11100: hit = 6'd5;   // w
                    5'b11101: hit = 6'd8;   // x
                    5'b11110: hit = 6'd21;  // y
                    5'b11111: hit = 6'd4;   // z
                    default: ;
                endcase
            end
        // ------------------------------
        // alphanumeric, second frame
        // ------------------------------
        end else if (bus.exc && bus.an) begin
            if (an_code <= 6'd9) begin
                hit = digit_mag[an_code[3:0]];
            end else begin
                unique0 case (an_code)
                    g15_code_pkg::code_an_cr:    mag_cr = 1'b1;
                    g15_code_pkg::code_an_tab:   mag_tab = 1'b1;
                    g15_code_pkg::code_an_space: mag_space = 1'b1;
                    6'b001011: spec = typewriter_pkg::mag_equal;
                    6'b010000: spec = typewriter_pkg::mag_plus;
                    6'b011100: spec = typewriter_pkg::mag_rparen;
                    6'b101011: spec = typewriter_pkg::mag_dollar;
                    6'b101100: spec = typewriter_pkg::mag_star;
                    6'b110001: spec = typewriter_pkg::mag_slash;
                    6'b111100: spec = typewriter_pkg::mag_lparen;
                    6'b010001: hit = 6'd2;   // a
                    6'b010010: hit = 6'd20;  // b
                    6'b010011: hit = 6'd12;  // c
                    6'b010100: hit = 6'd10;  // d
                    6'b010101: hit = 6'd9;   // e
                    6'b010110: hit = 6'd14;  // f
                    6'b010111: hit = 6'd18;  // g
                    6'b011000: hit = 6'd22;  // h
                    6'b011001: hit = 6'd29;  // i
                    6'b011010: hit = 6'd42;  // < >
                    6'b011011: hit = 6'd36;  // . ?
                    6'b011101: hit = 6'd38;  // : ;
                    6'b011110: hit = 6'd41;  // and/or
                    6'b100000: hit = typewriter_pkg::mag_star;  // -
                    6'b100001: hit = 6'd26;  // j
                    6'b100010: hit = 6'd30;  // k
                    6'b100011: hit = 6'd34;  // l
                    6'b100100: hit = 6'd28;  // m
                    6'b100101: hit = 6'd24;  // n
                    6'b100110: hit = 6'd33;  // o
                    6'b100111: hit = 6'd37;  // p
                    6'b101000: hit = 6'd1;   // q
                    6'b101001: hit = 6'd13;  // r
                    6'b110010: hit = 6'd6;   // s
                    6'b110011: hit = 6'd17;  // t
                    6'b110100: hit = 6'd25;  // u
                    6'b110101: hit = 6'd16;  // v
                    6'b110110: hit = 6'd5;   // w
                    6'b111000: hit = 6'd21;  // y
                    6'b111001: hit = 6'd4;   // z
                    6'b111011: hit = 6'd32;  // , and up arrow
                    default: ;
                endcase
            end
        end

        if (hit < typewriter_pkg::mag_count) mag_base[hit] = 1'b1;
        special     = (spec != none);
        special_mag = special ? spec : 6'd0;

        // one row of the diode matrix at a time
        a_one_row: assert ($onehot0({mag_base, mag_cr, mag_tab, mag_space, special}));
    end

endmodule

// ==== shift_control.sv ====
// shift relays RY11A/RY11B/RY14 and magnet drive; shift_up is the basket contact, already debounced
module shift_control (
    input  logic                 CLOCK,
    input  logic                 reset,
    input  logic                 tick_ms,
    relay_if.shift               bus,
    input  logic                 shift_up,      // basket up contact
    input  logic                 special,
    input  logic [5:0]           special_mag,
    input  typewriter_pkg::mag_t mag_base,
    output typewriter_pkg::mag_t mag,
    output logic                 mag_shift,
    output logic                 f_b            // basket in motion
);

    logic ry11a_e;
    logic ry11a;        // shift
    logic ry11b;        // shift interlock
    logic ry14_e;
    logic ry14;         // basket is up

    // ------------------------------
    // shift relays
    // ------------------------------
    assign ry11a_e = ((bus.an & bus.lev[5])          // alpha first frame
                   | (bus.type_on & ry11a)           // self hold
                   | (special & ~ry11b))             // shifted symbol
                   & ~(bus.lev[5] & bus.lev[3]);     // release code
    assign ry14_e  = bus.an & shift_up;

    relay ry11a_shift (
        .CLOCK, .reset, .tick(tick_ms), .e(ry11a_e), .ar(1'b0), .c(ry11a));

    relay #(.t_pick(typewriter_pkg::ticks_pick_int)) ry11b_int (
        .CLOCK, .reset, .tick(tick_ms), .e(ry11a), .ar(1'b0), .c(ry11b));

    relay ry14_up (
        .CLOCK, .reset, .tick(tick_ms), .e(ry14_e), .ar(1'b0), .c(ry14));

    // ------------------------------
    // magnet drive and feedback
    // ------------------------------
    always_comb begin
        mag = mag_base;
        if (special && ry11b) mag[special_mag] = 1'b1;  // symbol strikes once interlocked
    end

    assign mag_shift = ry11a;
    assign f_b       = bus.type_on & (ry11a ^ ry14);    // shift magnet and basket disagree

    // a shifted symbol strikes only while the shift relay still holds
    a_special_shifted: assert property (@(posedge CLOCK) disable iff (reset)
        (special && ry11b) |-> ry11a);

endmodule

// ==== anc_writer.sv ====
// ANC-2 output half; no fixed latency, the G-15 must hold exc until f_b is low
module anc_writer (
    input  logic                 CLOCK,
    input  logic                 reset,
    input  logic                 tick_ms,       // 1 ms strobe
    input  logic                 an,
    input  logic                 type_sel,
    input  logic                 exc,
    input  g15_code_pkg::lev_t   lev_in,
    input  logic                 shift_up,
    output typewriter_pkg::mag_t mag,
    output logic                 mag_cr,
    output logic                 mag_tab,
    output logic                 mag_space,
    output logic                 mag_shift,
    output logic                 f_b
);

    relay_if bus ();

    typewriter_pkg::mag_t mag_base;
    logic                 special;
    logic [5:0]           special_mag;

    relay_capture u_capture (
        .CLOCK, .reset, .tick_ms,
        .an_in(an), .type_in(type_sel), .exc_in(exc), .lev_in,
        .bus(bus.capture));

    char_decoder u_decode (
        .bus(bus.decode),
        .mag_base, .mag_cr, .mag_tab, .mag_space, .special, .special_mag);

    shift_control u_shift (
        .CLOCK, .reset, .tick_ms,
        .bus(bus.shift),
        .shift_up, .special, .special_mag, .mag_base,
        .mag, .mag_shift, .f_b);

endmodule

// ==== tb_anc_writer.sv ====
// directed testbench; carriage basket is a 30 ms delay model, characters are sent one at a time
module tb_anc_writer;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int n_chars      = 17;                   // 13 numeric, 3 alpha, 1 with TYPE off
    localparam int watchdog_ns  = n_chars * 80 * 4 * 40;
    localparam int wait_ticks   = 60;                   // bound on every output wait
    localparam int basket_ticks = 30;
    localparam int sel_cr       = 44;                   // output selectors past the magnets
    localparam int sel_tab      = 45;
    localparam int sel_space    = 46;
    localparam int sel_shift    = 47;
    localparam int sel_fb       = 48;

    // IBM digit magnets for 0..9
    localparam int digit_mag [10] = '{35, 39, 3, 7, 11, 15, 19, 23, 27, 31};

    logic                 CLOCK = 1'b0;
    logic                 reset = 1'b1;
    logic                 tick_ms = 1'b0;
    logic                 an = 1'b0;
    logic                 type_sel = 1'b0;
    logic                 exc = 1'b0;
    g15_code_pkg::lev_t   lev_in = '0;
    logic                 shift_up = 1'b0;     // basket contact
    typewriter_pkg::mag_t mag;
    logic                 mag_cr;
    logic                 mag_tab;
    logic                 mag_space;
    logic                 mag_shift;
    logic                 f_b;
    logic [1:0]           tick_div = '0;
    logic [4:0]           basket_cnt = '0;
    integer               seed = 32'h5c3f;
    int                   errors = 0;
    int                   tests = 0;
    int                   test_errors = 0;   // errors seen before the current test

    anc_writer DUT (.*);

    // ------------------------------
    // clock, ms strobe, basket
    // ------------------------------
    always #20 CLOCK = ~CLOCK;

    always @(posedge CLOCK) begin
        tick_div <= tick_div + 1'b1;
        tick_ms  <= (tick_div == 2'd3);             // one clock in four
    end

    always @(posedge CLOCK) begin
        if (reset) begin
            shift_up   <= 1'b0;
            basket_cnt <= '0;
        end else if (mag_shift == shift_up) begin
            basket_cnt <= '0;                       // basket at rest
        end else if (tick_ms) begin
            if (basket_cnt == basket_ticks - 1) begin
                shift_up   <= mag_shift;            // travel complete
                basket_cnt <= '0;
            end else begin
                basket_cnt <= basket_cnt + 1'b1;
            end
        end
    end

    // ------------------------------
    // helpers
    // ------------------------------
    function automatic logic output_bit(input int sel);
        case (sel)
            sel_cr:    return mag_cr;
            sel_tab:   return mag_tab;
            sel_space: return mag_space;
            sel_shift: return mag_shift;
            sel_fb:    return f_b;
            default:   return mag[sel];
        endcase
    endfunction

    task automatic value_error(input string name, input logic [63:0] got, input logic [63:0] exp);
        $display("FAILED %s got 0x%h expected 0x%h at %0t ns", name, got, exp, $time);
        errors++;
    endtask

    task automatic wait_clocks_of(input int ticks);
        repeat (ticks * 4) @(posedge CLOCK);
    endtask

    task automatic drive(input g15_code_pkg::lev_t lev, input logic strobe);
        @(posedge CLOCK);
        lev_in <= lev;
        exc    <= strobe;
    endtask

    task automatic wait_output(input int sel, input logic level);
        int n;
        n = 0;
        @(negedge CLOCK);
        while (output_bit(sel) !== level && n < wait_ticks * 4) begin
            @(negedge CLOCK);
            n++;
        end
        if (output_bit(sel) !== level) begin
            $display("timeout: output %0d never went to %0b", sel, level);
            errors++;
        end
    endtask

    task automatic check_struck(input int sel);
        logic [46:0] exp;                           // {space, tab, cr, mag}
        exp      = '0;
        exp[sel] = 1'b1;
        if ({mag_space, mag_tab, mag_cr, mag} !== exp)
            value_error("mag_space,mag_tab,mag_cr,mag", {mag_space, mag_tab, mag_cr, mag}, exp);
    endtask

    task automatic finish_test(input string name);
        tests++;
        $display("%-8s done, %0d errors", name, errors - test_errors);
        test_errors = errors;
    endtask

    task automatic type_numeric(input g15_code_pkg::lev_t code, input int sel);
        drive(code, 1'b1);
        wait_output(sel, 1'b1);
        check_struck(sel);
        drive('0, 1'b0);
        wait_output(sel, 1'b0);                     // RY9 drop
        wait_clocks_of(15);                         // slow level drop
    endtask

    task automatic type_alpha(input logic [5:0] code, input int sel);
        drive({1'b1, 2'b00, code[5:4]}, 1'b0);      // first frame, alpha on LEV2/LEV1
        wait_output(sel_shift, 1'b1);
        if (f_b !== 1'b1) value_error("f_b", f_b, 1);
        wait_output(sel_fb, 1'b0);                  // basket up
        if (shift_up !== 1'b1) value_error("shift_up", shift_up, 1);
        if ({mag_space, mag_tab, mag_cr, mag} !== '0)
            value_error("mag_space,mag_tab,mag_cr,mag", {mag_space, mag_tab, mag_cr, mag}, 0);
        drive({1'b0, code[3:0]}, 1'b1);             // second frame
        wait_output(sel, 1'b1);
        check_struck(sel);
        drive('0, 1'b0);
        wait_output(sel, 1'b0);
        wait_clocks_of(12);
        drive(5'b10100, 1'b0);                      // LEV5 with LEV3 drops the shift
        wait_output(sel_shift, 1'b0);
        wait_output(sel_fb, 1'b0);                  // basket back down
        drive('0, 1'b0);
        wait_clocks_of(25);
    endtask

    // ------------------------------
    // tests
    // ------------------------------
    task automatic test_reset();
        @(negedge CLOCK);
        if ({mag_space, mag_tab, mag_cr, mag} !== '0)
            value_error("mag_space,mag_tab,mag_cr,mag", {mag_space, mag_tab, mag_cr, mag}, 0);
        if (mag_shift !== 1'b0) value_error("mag_shift", mag_shift, 0);
        if (f_b !== 1'b0) value_error("f_b", f_b, 0);
        finish_test("reset");
    endtask

    task automatic test_type_off();
        int hits;
        hits = 0;
        drive(5'b10101, 1'b1);
        repeat (wait_ticks * 4) begin
            @(negedge CLOCK);
            if ({mag_space, mag_tab, mag_cr, mag} !== '0) hits++;
        end
        if (hits != 0) begin
            $display("a magnet was driven while TYPE was off");
            errors++;
        end
        drive('0, 1'b0);
        finish_test("type_off");
    endtask

    task automatic test_numeric();
        g15_code_pkg::lev_t codes [13];
        int                 sels [13];
        g15_code_pkg::lev_t t_code;
        int                 t_sel;
        int                 j;
        @(posedge CLOCK);
        type_sel <= 1'b1;
        wait_clocks_of(typewriter_pkg::ticks_pick + 5);     // RY10 pick
        for (int d = 0; d < 10; d++) begin
            codes[d] = {1'b1, 4'(d)};
            sels[d]  = digit_mag[d];
        end
        codes[10] = g15_code_pkg::code_num_space;
        sels[10]  = sel_space;
        codes[11] = g15_code_pkg::code_num_cr;
        sels[11]  = sel_cr;
        codes[12] = g15_code_pkg::code_num_tab | 5'b01000;   // LEV4 is don't care here
        sels[12]  = sel_tab;
        for (int i = 12; i > 0; i--) begin                  // shuffle the order
            j        = $unsigned($random(seed)) % (i + 1);
            t_code   = codes[i];
            t_sel    = sels[i];
            codes[i] = codes[j];
            sels[i]  = sels[j];
            codes[j] = t_code;
            sels[j]  = t_sel;
        end
        for (int i = 0; i < 13; i++) type_numeric(codes[i], sels[i]);
        finish_test("numeric");
    endtask

    task automatic test_alpha();
        @(posedge CLOCK);
        an <= 1'b1;
        wait_clocks_of(typewriter_pkg::ticks_pick + 5);     // RY8 pick
        type_alpha(6'b010001, 2);                           // a
        type_alpha(6'b101000, 1);                           // q
        finish_test("alpha");
    endtask

    task automatic test_special();
        type_alpha(6'b001011, 15);                          // = strikes after the shift
        finish_test("special");
    endtask

    initial begin
        repeat (4) @(posedge CLOCK);
        reset <= 1'b0;
        test_reset();
        test_type_off();
        test_numeric();
        test_alpha();
        test_special();
        $display("tests: %0d, errors: %0d", tests, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("watchdog expired after %0d ns, run did not complete", watchdog_ns);
        $display("Checks failed");
        $finish;
    end

endmodule

// ==== vlog.f ====
g15_code_pkg.sv
typewriter_pkg.sv
relay_if.sv
relay.sv
relay_capture.sv
char_decoder.sv
shift_control.sv
anc_writer.sv
tb_anc_writer.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module tb_anc_writer -o sim_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q "^All checks passed$"; then
    exit 0
fi
exit 1
